// ==== cpu_core.f ====
design/cpu_pkg.sv
design/control_decoder.sv
design/register_file.sv
design/hazard_unit.sv
design/datapath.sv
design/mem_arbiter.sv
design/cpu_top.sv
testbench/tb_cpu_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the cpu core testbench with Verilator and run it
# exit status is non-zero when the build or the simulation fails

verilator --binary -Wno-fatal --top-module tb_cpu_top -f cpu_core.f -o tb_cpu_top \
   && ./obj_dir/tb_cpu_top \
   || { echo "simulation failed"; exit 1; }

// ==== testbench/tb_cpu_top.sv ====
//////////////////////////////////////////////////
// cpu core testbench
// random program checked against an isa model,
// apb slave memory with random wait states
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_top;
   import cpu_pkg::*;

   localparam word_t PC_INIT    = 32'h0;
   localparam int    MEM_WORDS  = 512;
   localparam int    PROG_LEN   = 60;      // halt sits at this word
   localparam int    DATA_BASE  = 256;     // word index of byte address 0x400
   localparam int    DATA_WORDS = 16;
   localparam int    TIMEOUT    = (PROG_LEN + 1) * 12 + 200;

   logic     CLK;
   logic     nRST;
   apb_req_t apb_out;
   apb_rsp_t apb_in;
   logic     halt;

   word_t       mem     [MEM_WORDS];       // memory seen by the dut
   word_t       ref_mem [MEM_WORDS];       // model copy
   apb_req_t    exp_stores [$];
   logic [31:0] seed      = 32'hea6e;
   int          cycle_cnt = 0;

   cpu_top #(.PC_INIT(PC_INIT)) dut (
      .CLK, .nRST, .apb_out, .apb_in, .halt
   );

   always #5 CLK = ~CLK;

   //////////////////////////////////////////////////
   // helpers
   //////////////////////////////////////////////////
   function automatic logic [31:0] xorshift32();
      seed = seed ^ (seed << 13);
      seed = seed ^ (seed >> 17);
      seed = seed ^ (seed << 5);
      return seed;
   endfunction

   function automatic regbits_t rand_reg();
      return regbits_t'(xorshift32() % 7 + 1);   // r1..r7 only
   endfunction

   function automatic word_t rtype_word(funct_t f, regbits_t rs, regbits_t rt, regbits_t rd);
      instr_u w;
      w.r = '{opcode: OP_RTYPE, rs: rs, rt: rt, rd: rd, shamt: 5'd0, funct: f};
      return w;
   endfunction

   function automatic word_t itype_word(opcode_t op, regbits_t rs, regbits_t rt,
                                        logic [15:0] imm);
      instr_u w;
      w.i = '{opcode: op, rs: rs, rt: rt, imm16: imm};
      return w;
   endfunction

   task automatic stop_with_failure();
      $display("ERRORS FOUND");
      $fatal(1, "run stopped at first failure");
   endtask

   task automatic check_word(input string name, input word_t want, input word_t got);
      if (got !== want) begin
         $display("ERR %s expected %h actual %h", name, want, got);
         stop_with_failure();
      end
   endtask

   task automatic check_apb(input string name, input apb_req_t want, input apb_req_t got);
      if (got !== want) begin
         $display("ERR %s expected %b%b%b %h %h actual %b%b%b %h %h", name,
                  want.psel, want.penable, want.pwrite, want.paddr, want.pwdata,
                  got.psel, got.penable, got.pwrite, got.paddr, got.pwdata);
         stop_with_failure();
      end
   endtask

   task automatic expect_idle(input string name);
      apb_req_t want;
      want         = apb_out;              // addr and data unused while idle
      want.psel    = 1'b0;
      want.penable = 1'b0;
      want.pwrite  = 1'b0;
      check_apb(name, want, apb_out);
      if (halt !== 1'b0) begin
         $display("halt is not low during %s", name);
         stop_with_failure();
      end
   endtask

   //////////////////////////////////////////////////
   // program and model
   //////////////////////////////////////////////////
   task automatic gen_program();
      funct_t      fsel [5] = '{F_ADDU, F_SUBU, F_AND, F_OR, F_SLT};
      logic [31:0] r;
      logic [31:0] v;
      logic [15:0] daddr;
      int          kind, dmax, off;
      for (int a = 0; a < MEM_WORDS; a++)
         mem[a] = (a * 4) ^ 32'h5a5a_5a5a;  // keyed to byte address
      for (int k = 0; k < DATA_WORDS; k++)
         mem[DATA_BASE + k] = xorshift32();
      for (int i = 0; i < PROG_LEN; i++) begin
         r     = xorshift32();
         v     = xorshift32();
         kind  = int'(r[3:0]);
         daddr = {10'h010, r[7:4], 2'b00};  // 0x400 + 4 * word
         dmax  = PROG_LEN - 1 - i;          // forward room up to the halt
         off   = 1 + int'(r[9:8]);
         if (off > dmax)
            off = dmax;
         if (kind >= 11 && kind <= 13 && dmax < 1)
            kind = 0;
         case (kind)
            4, 5, 15: mem[i] = itype_word(OP_ADDIU, rand_reg(), rand_reg(), v[15:0]);
            6:        mem[i] = itype_word(OP_LUI, 5'd0, rand_reg(), v[15:0]);
            7, 8:     mem[i] = itype_word(OP_LW, 5'd0, rand_reg(), daddr);
            9, 10:    mem[i] = itype_word(OP_SW, 5'd0, rand_reg(), daddr);
            11:       mem[i] = itype_word(OP_BEQ, rand_reg(), rand_reg(), 16'(off));
            12:       mem[i] = itype_word(OP_BNE, rand_reg(), rand_reg(), 16'(off));
            13:       mem[i] = {OP_J, 26'(i + 1 + off)};
            default:  mem[i] = rtype_word(fsel[int'(r[12:10]) % 5], rand_reg(),
                                          rand_reg(), rand_reg());
         endcase
      end
      mem[PROG_LEN] = {OP_HALT, 26'h0};
   endtask

   // plain sequential isa run, one instruction per step
   task automatic run_model();
      word_t    regs [32];
      word_t    pc, npc, a, b, val, addr, imm_s, iw;
      instr_u   ins;
      apb_req_t st;
      logic     done;
      int       steps;
      for (int n = 0; n < 32; n++)
         regs[n] = '0;
      for (int n = 0; n < MEM_WORDS; n++)
         ref_mem[n] = mem[n];
      pc    = PC_INIT;
      done  = 1'b0;
      steps = 0;
      while (!done && steps < 1000) begin
         iw    = ref_mem[pc[10:2]];
         ins   = instr_u'(iw);
         npc   = pc + 32'd4;
         a     = regs[ins.r.rs];
         b     = regs[ins.r.rt];
         imm_s = {{16{iw[15]}}, iw[15:0]};
         case (ins.r.opcode)
            OP_RTYPE: begin
               case (ins.r.funct)
                  F_ADDU:  val = a + b;
                  F_SUBU:  val = a - b;
                  F_AND:   val = a & b;
                  F_OR:    val = a | b;
                  F_SLT:   val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                  default: val = regs[ins.r.rd];   // unknown funct acts as nop
               endcase
               regs[ins.r.rd] = val;
            end
            OP_ADDIU: regs[ins.i.rt] = a + imm_s;
            OP_LUI:   regs[ins.i.rt] = {iw[15:0], 16'h0};
            OP_LW: begin
               addr           = a + imm_s;
               regs[ins.i.rt] = ref_mem[addr[10:2]];
            end
            OP_SW: begin
               addr                = a + imm_s;
               ref_mem[addr[10:2]] = b;
               st = '{psel: 1'b1, penable: 1'b1, pwrite: 1'b1, paddr: addr, pwdata: b};
               exp_stores.push_back(st);
            end
            OP_BEQ:  if (a == b) npc = npc + {imm_s[29:0], 2'b00};
            OP_BNE:  if (a != b) npc = npc + {imm_s[29:0], 2'b00};
            OP_J:    npc = {npc[31:28], iw[25:0], 2'b00};
            OP_HALT: done = 1'b1;
            default: ;
         endcase
         regs[0] = '0;
         pc      = npc;
         steps++;
      end
      if (!done) begin
         $display("reference model never reached the halt instruction");
         stop_with_failure();
      end
   endtask

   //////////////////////////////////////////////////
   // timeout
   //////////////////////////////////////////////////
   always @(posedge CLK) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT) begin
         $display("timeout, the core did not halt within %0d cycles", TIMEOUT);
         stop_with_failure();
      end
   end

   //////////////////////////////////////////////////
   // reset, apb slave and checks
   //////////////////////////////////////////////////
   initial begin
      apb_req_t   held, want;
      logic [8:0] widx;
      int         wait_left, store_idx, hold_cnt;
      logic       in_xfer, prev_psel, first_seen, halt_seen;
      CLK        = 1'b0;
      nRST       = 1'b0;
      apb_in     = '0;
      held       = '0;
      wait_left  = 0;
      store_idx  = 0;
      hold_cnt   = 0;
      in_xfer    = 1'b0;
      prev_psel  = 1'b0;
      first_seen = 1'b0;
      halt_seen  = 1'b0;
      gen_program();
      run_model();
      $display("program of %0d words, %0d stores expected", PROG_LEN + 1, exp_stores.size());
      repeat (10) begin
         @(posedge CLK);
         #1;
         expect_idle("reset");
      end
      nRST = 1'b1;

      while (hold_cnt < 10) begin
         @(posedge CLK);
         #1;
         if (apb_out.psel && !apb_out.penable) begin
            if (prev_psel || in_xfer) begin
               $display("setup phase at %h without an idle cycle before it", apb_out.paddr);
               stop_with_failure();
            end
            if (halt_seen) begin
               $display("an APB transfer started after halt");
               stop_with_failure();
            end
            if (!first_seen) begin
               want        = apb_out;
               want.pwrite = 1'b0;
               want.paddr  = PC_INIT;
               check_apb("first_fetch", want, apb_out);
               first_seen  = 1'b1;
            end
            held          = apb_out;
            wait_left     = int'(xorshift32() % 4);
            in_xfer       = 1'b1;
            apb_in.pready = 1'b0;
         end else if (apb_out.penable) begin
            if (!in_xfer) begin
               $display("APB access phase without a setup phase before it");
               stop_with_failure();
            end
            want         = held;
            want.penable = 1'b1;
            check_apb("apb_hold", want, apb_out);
            if (wait_left > 0) begin
               wait_left--;
               apb_in.pready = 1'b0;
            end else begin
               if (apb_out.paddr[1:0] != 2'b00 || apb_out.paddr[31:11] != 21'h0) begin
                  $display("APB address %h is outside the test memory", apb_out.paddr);
                  stop_with_failure();
               end
               widx = apb_out.paddr[10:2];
               if (apb_out.pwrite) begin
                  if (store_idx >= exp_stores.size()) begin
                     $display("APB write to %h after the last expected store", apb_out.paddr);
                     stop_with_failure();
                  end
                  check_apb($sformatf("store_%0d", store_idx), exp_stores[store_idx], apb_out);
                  store_idx++;
                  mem[widx] = apb_out.pwdata;
               end else begin
                  apb_in.prdata = mem[widx];
               end
               apb_in.pready = 1'b1;       // transfer ends on the next edge
               in_xfer       = 1'b0;
            end
         end else begin
            apb_in.pready = 1'b0;
            if (in_xfer) begin
               $display("psel dropped before the transfer completed");
               stop_with_failure();
            end
            if (!first_seen)
               expect_idle("idle_before_fetch");
         end
         prev_psel = apb_out.psel;
         if (halt)
            halt_seen = 1'b1;
         else if (halt_seen) begin
            $display("halt went low again after it was set");
            stop_with_failure();
         end
         if (halt_seen)
            hold_cnt++;
      end

      // data region against the model after halt
      for (int k = 0; k < DATA_WORDS; k++)
         check_word($sformatf("data_%0d", k), ref_mem[DATA_BASE + k], mem[DATA_BASE + k]);
      if (store_idx != exp_stores.size()) begin
         $display("halt after %0d of %0d expected stores", store_idx, exp_stores.size());
         stop_with_failure();
      end else begin
         $display("NO ERRORS");
         $finish;
      end
   end

endmodule

`default_nettype wire

// ==== design/cpu_top.sv ====
//////////////////////////////////////////////////
// cpu top
// five stage core with one apb memory port
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module cpu_top #(
   parameter cpu_pkg::word_t PC_INIT = 32'h0
) (
   input  logic              CLK,
   input  logic              nRST,
   output cpu_pkg::apb_req_t apb_out,
   input  cpu_pkg::apb_rsp_t apb_in,
   output logic              halt
);
   import cpu_pkg::*;

   mem_req_t fetch_req, data_req;
   mem_rsp_t fetch_rsp, data_rsp;
   instr_u   instr;
   ctrl_t    ctrl;
   regbits_t rsel1, rsel2, wsel;
   regbits_t de_rs, de_rt, em_wsel, mw_wsel, fd_rs, fd_rt, de_wsel;
   word_t    wdat, rdat1, rdat2;
   logic     wen, em_reg_write, mw_reg_write, de_mem_read;
   logic     redirect, fetch_wait, data_wait;
   logic     advance, load_stall, flush;
   fwd_sel_t fwd_a, fwd_b;

   datapath #(.PC_INIT(PC_INIT)) u_datapath (
      .CLK, .nRST, .fetch_req, .data_req, .fetch_rsp, .data_rsp,
      .instr, .ctrl, .rsel1, .rsel2, .wsel, .wen, .wdat, .rdat1, .rdat2,
      .de_rs, .de_rt, .em_wsel, .mw_wsel, .fd_rs, .fd_rt, .de_wsel,
      .em_reg_write, .mw_reg_write, .de_mem_read, .redirect,
      .fetch_wait, .data_wait, .fwd_a, .fwd_b, .advance, .load_stall,
      .flush, .halt
   );

   control_decoder u_decoder (.instr, .ctrl);

   register_file u_regfile (
      .CLK, .nRST, .rsel1, .rsel2, .wsel, .wen, .wdat, .rdat1, .rdat2
   );

   hazard_unit u_hazard (
      .de_rs, .de_rt, .em_wsel, .mw_wsel, .fd_rs, .fd_rt, .de_wsel,
      .em_reg_write, .mw_reg_write, .de_mem_read, .redirect,
      .fetch_wait, .data_wait, .fwd_a, .fwd_b, .advance, .load_stall, .flush
   );

   mem_arbiter u_arbiter (
      .CLK, .nRST, .fetch_req, .data_req, .fetch_rsp, .data_rsp,
      .apb_out, .apb_in
   );

endmodule

`default_nettype wire

// ==== design/mem_arbiter.sv ====
//////////////////////////////////////////////////
// memory arbiter
// fetch and data share one apb master, data first
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
   input  logic              CLK,
   input  logic              nRST,
   input  cpu_pkg::mem_req_t fetch_req,
   input  cpu_pkg::mem_req_t data_req,
   output cpu_pkg::mem_rsp_t fetch_rsp,
   output cpu_pkg::mem_rsp_t data_rsp,
   output cpu_pkg::apb_req_t apb_out,
   input  cpu_pkg::apb_rsp_t apb_in
);
   import cpu_pkg::*;

   typedef enum logic [1:0] {
      ARB_IDLE, ARB_SETUP, ARB_ACCESS
   } arb_state_t;

   arb_state_t state;
   logic       own_data;    // owner of current transfer
   mem_req_t   sel_req;
   logic       xfer_done;

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         state    <= ARB_IDLE;
         own_data <= 1'b0;
      end else begin
         case (state)
            ARB_IDLE: begin
               if (data_req.valid) begin
                  own_data <= 1'b1;
                  state    <= ARB_SETUP;
               end else if (fetch_req.valid) begin
                  own_data <= 1'b0;
                  state    <= ARB_SETUP;
               end
            end
            ARB_SETUP:  state <= ARB_ACCESS;
            ARB_ACCESS: if (apb_in.pready) state <= ARB_IDLE;
            default:    state <= ARB_IDLE;
         endcase
      end
   end

   // owner holds its request stable until done
   assign sel_req = own_data ? data_req : fetch_req;

   assign apb_out.psel    = state != ARB_IDLE;
   assign apb_out.penable = state == ARB_ACCESS;
   assign apb_out.pwrite  = apb_out.psel && sel_req.write;
   assign apb_out.paddr   = apb_out.psel ? sel_req.addr : '0;
   assign apb_out.pwdata  = apb_out.psel ? sel_req.wdata : '0;

   assign xfer_done = state == ARB_ACCESS && apb_in.pready;

   assign fetch_rsp.done  = xfer_done && !own_data;
   assign fetch_rsp.rdata = apb_in.prdata;
   assign data_rsp.done   = xfer_done && own_data;
   assign data_rsp.rdata  = apb_in.prdata;

endmodule

`default_nettype wire

// ==== design/datapath.sv ====
//////////////////////////////////////////////////
// datapath
// pc, pipeline latches, alu, forwarding, branch
// resolve in execute, writeback select, sticky halt
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module datapath #(
   parameter cpu_pkg::word_t PC_INIT = 32'h0
) (
   input  logic              CLK,
   input  logic              nRST,
   output cpu_pkg::mem_req_t fetch_req,
   output cpu_pkg::mem_req_t data_req,
   input  cpu_pkg::mem_rsp_t fetch_rsp,
   input  cpu_pkg::mem_rsp_t data_rsp,
   output cpu_pkg::instr_u   instr,
   input  cpu_pkg::ctrl_t    ctrl,
   output cpu_pkg::regbits_t rsel1,
   output cpu_pkg::regbits_t rsel2,
   output cpu_pkg::regbits_t wsel,
   output logic              wen,
   output cpu_pkg::word_t    wdat,
   input  cpu_pkg::word_t    rdat1,
   input  cpu_pkg::word_t    rdat2,
   output cpu_pkg::regbits_t de_rs,
   output cpu_pkg::regbits_t de_rt,
   output cpu_pkg::regbits_t em_wsel,
   output cpu_pkg::regbits_t mw_wsel,
   output cpu_pkg::regbits_t fd_rs,
   output cpu_pkg::regbits_t fd_rt,
   output cpu_pkg::regbits_t de_wsel,
   output logic              em_reg_write,
   output logic              mw_reg_write,
   output logic              de_mem_read,
   output logic              redirect,
   output logic              fetch_wait,
   output logic              data_wait,
   input  cpu_pkg::fwd_sel_t fwd_a,
   input  cpu_pkg::fwd_sel_t fwd_b,
   input  logic              advance,
   input  logic              load_stall,
   input  logic              flush,
   output logic              halt
);
   import cpu_pkg::*;

   word_t     pc, target;
   fd_latch_t fd;
   de_latch_t de, de_next;
   em_latch_t em, em_next;
   mw_latch_t mw, mw_next;
   logic      fetch_stop, fetch_en;
   logic      fetch_ok, data_ok;       // transfer finished, waiting for advance
   word_t     fetch_buf, data_buf, instr_word, load_data;
   word_t     op_a, op_b_reg, op_b, alu_res;
   logic      taken;

   //////////////////////////////////////////////////
   // memory requests
   //////////////////////////////////////////////////
   assign fetch_en = !fetch_stop && !ctrl.halt;   // no fetch once halt is decoded

   assign fetch_req.valid = fetch_en && !fetch_ok;
   assign fetch_req.write = 1'b0;
   assign fetch_req.addr  = pc;
   assign fetch_req.wdata = '0;

   assign data_req.valid = (em.mem_read || em.mem_write) && !data_ok;
   assign data_req.write = em.mem_write;
   assign data_req.addr  = em.alu_res;
   assign data_req.wdata = em.store_data;

   assign fetch_wait = fetch_req.valid && !fetch_rsp.done;
   assign data_wait  = data_req.valid && !data_rsp.done;

   assign instr_word = fetch_ok ? fetch_buf : fetch_rsp.rdata;
   assign load_data  = data_ok ? data_buf : data_rsp.rdata;

   // hold finished results while the other side still waits
   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         fetch_ok <= 1'b0;
         data_ok  <= 1'b0;
      end else if (advance) begin
         fetch_ok <= 1'b0;
         data_ok  <= 1'b0;
      end else begin
         if (fetch_rsp.done) fetch_ok <= 1'b1;
         if (data_rsp.done)  data_ok  <= 1'b1;
      end
   end

   always_ff @(posedge CLK) begin
      if (fetch_rsp.done) fetch_buf <= fetch_rsp.rdata;
      if (data_rsp.done)  data_buf  <= data_rsp.rdata;
   end

   //////////////////////////////////////////////////
   // decode
   //////////////////////////////////////////////////
   assign instr = fd.instr;
   assign rsel1 = fd.instr.r.rs;
   assign rsel2 = fd.instr.r.rt;
   assign fd_rs = fd.instr.r.rs;
   assign fd_rt = fd.instr.r.rt;

   always_comb begin
      de_next.ctrl  = ctrl;
      de_next.rdat1 = rdat1;
      de_next.rdat2 = rdat2;
      if (ctrl.lui)
         de_next.imm = {fd.instr.i.imm16, 16'h0};
      else if (ctrl.sign_ext)
         de_next.imm = {{16{fd.instr.i.imm16[15]}}, fd.instr.i.imm16};
      else
         de_next.imm = {16'h0, fd.instr.i.imm16};
      de_next.jtarget   = {fd.pc_plus_4[31:28], fd.instr.i.rs, fd.instr.i.rt,
                           fd.instr.i.imm16, 2'b00};
      de_next.rs        = fd.instr.r.rs;
      de_next.rt        = fd.instr.r.rt;
      de_next.wsel      = ctrl.wsel_rt ? fd.instr.r.rt : fd.instr.r.rd;
      de_next.pc_plus_4 = fd.pc_plus_4;
   end

   //////////////////////////////////////////////////
   // execute
   //////////////////////////////////////////////////
   function automatic word_t fwd_mux(fwd_sel_t sel, word_t regval);
      case (sel)
         FWD_MEM: return em.alu_res;
         FWD_WB:  return wdat;
         default: return regval;
      endcase
   endfunction

   assign op_a     = fwd_mux(fwd_a, de.rdat1);
   assign op_b_reg = fwd_mux(fwd_b, de.rdat2);
   assign op_b     = de.ctrl.alu_src_imm ? de.imm : op_b_reg;

   always_comb begin
      case (de.ctrl.alu_op)
         ALU_SUB:   alu_res = op_a - op_b;
         ALU_AND:   alu_res = op_a & op_b;
         ALU_OR:    alu_res = op_a | op_b;
         ALU_SLT:   alu_res = {31'h0, $signed(op_a) < $signed(op_b)};
         ALU_PASSB: alu_res = op_b;         // lui
         default:   alu_res = op_a + op_b;
      endcase
   end

   assign taken    = (de.ctrl.branch_eq && op_a == op_b_reg) ||
                     (de.ctrl.branch_ne && op_a != op_b_reg);
   assign redirect = taken || de.ctrl.jump;
   assign target   = de.ctrl.jump ? de.jtarget : de.pc_plus_4 + {de.imm[29:0], 2'b00};

   assign de_rs       = de.rs;
   assign de_rt       = de.rt;
   assign de_wsel     = de.wsel;
   assign de_mem_read = de.ctrl.mem_read;

   assign em_next.reg_write  = de.ctrl.reg_write;
   assign em_next.mem_read   = de.ctrl.mem_read;
   assign em_next.mem_write  = de.ctrl.mem_write;
   assign em_next.halt       = de.ctrl.halt;
   assign em_next.alu_res    = alu_res;
   assign em_next.store_data = op_b_reg;
   assign em_next.wsel       = de.wsel;

   //////////////////////////////////////////////////
   // memory and writeback
   //////////////////////////////////////////////////
   assign em_wsel      = em.wsel;
   assign em_reg_write = em.reg_write;

   assign mw_next.reg_write  = em.reg_write;
   assign mw_next.mem_to_reg = em.mem_read;
   assign mw_next.halt       = em.halt;
   assign mw_next.alu_res    = em.alu_res;
   assign mw_next.load_data  = load_data;
   assign mw_next.wsel       = em.wsel;

   assign mw_wsel      = mw.wsel;
   assign mw_reg_write = mw.reg_write;
   assign wsel         = mw.wsel;
   assign wen          = mw.reg_write;
   assign wdat         = mw.mem_to_reg ? mw.load_data : mw.alu_res;

   //////////////////////////////////////////////////
   // pc and latches
   //////////////////////////////////////////////////
   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         pc         <= PC_INIT;
         fd         <= '0;
         de         <= '0;
         em         <= '0;
         mw         <= '0;
         fetch_stop <= 1'b0;
      end else if (advance) begin
         if (flush) begin
            pc <= target;
            fd <= '0;
         end else if (!load_stall) begin
            if (fetch_en) begin
               pc           <= pc + 32'd4;
               fd.instr     <= instr_u'(instr_word);
               fd.pc_plus_4 <= pc + 32'd4;
            end else begin
               fd <= '0;                   // nothing fetched, bubble
            end
         end
         de <= (flush || load_stall) ? '0 : de_next;
         em <= em_next;
         mw <= mw_next;
         if (ctrl.halt && !flush)
            fetch_stop <= 1'b1;            // halt moved into execute, no way back
      end
   end

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST)
         halt <= 1'b0;
      else if (mw.halt)
         halt <= 1'b1;
   end

endmodule

`default_nettype wire

// ==== design/hazard_unit.sv ====
//////////////////////////////////////////////////
// hazard unit
// forwarding selects, load-use stall, branch flush
// and the pipeline-wide memory wait
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
   input  cpu_pkg::regbits_t de_rs,
   input  cpu_pkg::regbits_t de_rt,
   input  cpu_pkg::regbits_t em_wsel,
   input  cpu_pkg::regbits_t mw_wsel,
   input  cpu_pkg::regbits_t fd_rs,
   input  cpu_pkg::regbits_t fd_rt,
   input  cpu_pkg::regbits_t de_wsel,
   input  logic              em_reg_write,
   input  logic              mw_reg_write,
   input  logic              de_mem_read,
   input  logic              redirect,
   input  logic              fetch_wait,
   input  logic              data_wait,
   output cpu_pkg::fwd_sel_t fwd_a,
   output cpu_pkg::fwd_sel_t fwd_b,
   output logic              advance,
   output logic              load_stall,
   output logic              flush
);
   import cpu_pkg::*;

   // memory stage is younger, so it wins over writeback
   function automatic fwd_sel_t pick_source(regbits_t src);
      if (em_reg_write && em_wsel != '0 && em_wsel == src)
         return FWD_MEM;
      else if (mw_reg_write && mw_wsel != '0 && mw_wsel == src)
         return FWD_WB;
      else
         return FWD_REG;
   endfunction

   assign fwd_a = pick_source(de_rs);
   assign fwd_b = pick_source(de_rt);

   // load in execute feeding the instr in decode
   assign load_stall = de_mem_read && de_wsel != '0 &&
                       (de_wsel == fd_rs || de_wsel == fd_rt);

   assign flush   = redirect;
   assign advance = !(fetch_wait || data_wait);   // any pending transfer freezes all

endmodule

`default_nettype wire

// ==== design/register_file.sv ====
//////////////////////////////////////////////////
// register file, 32 x 32
// r0 reads zero, same-cycle write shows on read
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module register_file (
   input  logic              CLK,
   input  logic              nRST,
   input  cpu_pkg::regbits_t rsel1,
   input  cpu_pkg::regbits_t rsel2,
   input  cpu_pkg::regbits_t wsel,
   input  logic              wen,
   input  cpu_pkg::word_t    wdat,
   output cpu_pkg::word_t    rdat1,
   output cpu_pkg::word_t    rdat2
);
   import cpu_pkg::*;

   word_t regs [31:1];

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         for (int i = 1; i < 32; i++)
            regs[i] <= '0;
      end else if (wen && wsel != '0) begin
         regs[wsel] <= wdat;
      end
   end

   function automatic word_t read_port(regbits_t sel);
      if (sel == '0)
         return '0;
      else if (wen && wsel == sel)
         return wdat;            // writeback bypass
      else
         return regs[sel];
   endfunction

   assign rdat1 = read_port(rsel1);
   assign rdat2 = read_port(rsel2);

endmodule

`default_nettype wire

// ==== design/control_decoder.sv ====
//////////////////////////////////////////////////
// control decoder
// opcode and funct to control bits, unknown = nop
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module control_decoder (
   input  cpu_pkg::instr_u instr,
   output cpu_pkg::ctrl_t  ctrl
);
   import cpu_pkg::*;

   always_comb begin
      ctrl = '0;
      case (instr.r.opcode)
         OP_RTYPE: begin
            ctrl.reg_write = 1'b1;
            case (instr.r.funct)
               F_ADDU:  ctrl.alu_op = ALU_ADD;
               F_SUBU:  ctrl.alu_op = ALU_SUB;
               F_AND:   ctrl.alu_op = ALU_AND;
               F_OR:    ctrl.alu_op = ALU_OR;
               F_SLT:   ctrl.alu_op = ALU_SLT;
               default: ctrl = '0;      // bad funct, drop the write too
            endcase
         end
         OP_ADDIU: begin
            ctrl.alu_src_imm = 1'b1;
            ctrl.sign_ext    = 1'b1;
            ctrl.reg_write   = 1'b1;
            ctrl.wsel_rt     = 1'b1;
         end
         OP_LUI: begin
            ctrl.alu_op      = ALU_PASSB;
            ctrl.alu_src_imm = 1'b1;
            ctrl.lui         = 1'b1;
            ctrl.reg_write   = 1'b1;
            ctrl.wsel_rt     = 1'b1;
         end
         OP_LW: begin
            ctrl.alu_src_imm = 1'b1;
            ctrl.sign_ext    = 1'b1;
            ctrl.reg_write   = 1'b1;
            ctrl.wsel_rt     = 1'b1;
            ctrl.mem_read    = 1'b1;
         end
         OP_SW: begin
            ctrl.alu_src_imm = 1'b1;
            ctrl.sign_ext    = 1'b1;
            ctrl.mem_write   = 1'b1;
         end
         OP_BEQ: begin
            ctrl.sign_ext  = 1'b1;      // offset is signed
            ctrl.branch_eq = 1'b1;
         end
         OP_BNE: begin
            ctrl.sign_ext  = 1'b1;
            ctrl.branch_ne = 1'b1;
         end
         OP_J:    ctrl.jump = 1'b1;
         OP_HALT: ctrl.halt = 1'b1;
         default: ctrl = '0;
      endcase
   end

endmodule

`default_nettype wire

// ==== design/cpu_pkg.sv ====
//////////////////////////////////////////////////
// cpu package
// shared widths, encodings, instruction views and
// pipeline latch and memory transfer structs
//////////////////////////////////////////////////
`default_nettype none

package cpu_pkg;

   typedef logic [31:0] word_t;
   typedef logic [4:0]  regbits_t;

   typedef enum logic [5:0] {
      OP_RTYPE = 6'h00,
      OP_J     = 6'h02,
      OP_BEQ   = 6'h04,
      OP_BNE   = 6'h05,
      OP_ADDIU = 6'h09,
      OP_LUI   = 6'h0f,
      OP_LW    = 6'h23,
      OP_SW    = 6'h2b,
      OP_HALT  = 6'h3f
   } opcode_t;

   typedef enum logic [5:0] {
      F_ADDU = 6'h21,
      F_SUBU = 6'h23,
      F_AND  = 6'h24,
      F_OR   = 6'h25,
      F_SLT  = 6'h2a
   } funct_t;

   typedef enum logic [2:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT, ALU_PASSB
   } alu_op_t;

   // two readings of one instruction word
   typedef struct packed {
      opcode_t    opcode;
      regbits_t   rs;
      regbits_t   rt;
      regbits_t   rd;
      logic [4:0] shamt;
      funct_t     funct;
   } r_type_t;

   typedef struct packed {
      opcode_t     opcode;
      regbits_t    rs;
      regbits_t    rt;
      logic [15:0] imm16;
   } i_type_t;

   typedef union packed {
      r_type_t r;
      i_type_t i;   // J target is the low 26 bits of this view
   } instr_u;

   typedef struct packed {
      alu_op_t alu_op;
      logic    alu_src_imm;
      logic    sign_ext;
      logic    lui;
      logic    reg_write;
      logic    wsel_rt;     // destination is rt, not rd
      logic    mem_read;
      logic    mem_write;
      logic    branch_eq;
      logic    branch_ne;
      logic    jump;
      logic    halt;
   } ctrl_t;

   //////////////////////////////////////////////////
   // pipeline latches
   //////////////////////////////////////////////////
   typedef struct packed {
      instr_u instr;
      word_t  pc_plus_4;
   } fd_latch_t;

   typedef struct packed {
      ctrl_t    ctrl;
      word_t    rdat1;
      word_t    rdat2;
      word_t    imm;        // already extended or shifted for lui
      word_t    jtarget;
      regbits_t rs;
      regbits_t rt;
      regbits_t wsel;
      word_t    pc_plus_4;
   } de_latch_t;

   typedef struct packed {
      logic     reg_write;
      logic     mem_read;
      logic     mem_write;
      logic     halt;
      word_t    alu_res;
      word_t    store_data;
      regbits_t wsel;
   } em_latch_t;

   typedef struct packed {
      logic     reg_write;
      logic     mem_to_reg;
      logic     halt;
      word_t    alu_res;
      word_t    load_data;
      regbits_t wsel;
   } mw_latch_t;

   typedef enum logic [1:0] {
      FWD_REG, FWD_MEM, FWD_WB
   } fwd_sel_t;

   //////////////////////////////////////////////////
   // memory side
   //////////////////////////////////////////////////
   typedef struct packed {
      logic  valid;
      logic  write;
      word_t addr;
      word_t wdata;
   } mem_req_t;

   typedef struct packed {
      logic  done;    // one cycle pulse
      word_t rdata;
   } mem_rsp_t;

   typedef struct packed {
      logic  psel;
      logic  penable;
      logic  pwrite;
      word_t paddr;
      word_t pwdata;
   } apb_req_t;

   typedef struct packed {
      logic  pready;
      word_t prdata;
   } apb_rsp_t;

endpackage

`default_nettype wire
